/* cart_loader.f */
+incdir+tests
hw/cart_pkg.sv
hw/load_decoder.sv
hw/rom_writer.sv
hw/cheat_assembler.sv
hw/rom_map.sv
hw/cart_loader.sv
tests/tb_cart_loader.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_cart_loader
FLIST = cart_loader.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

/* tests/tb_cart_model.svh */
// Testbench model: LCG step, expected result queues, mask and cheat rules, compare tasks
`ifndef TB_CART_MODEL_SVH
`define TB_CART_MODEL_SVH

	// ====================
	// Expected results
	// ====================

	cart_pkg::rom_write_t  exp_writes[$];
	cart_pkg::cheat_code_t exp_cheats[$];
	logic [ROM_ADDR_W-1:0] exp_maps[$];

	function automatic logic [31:0] lcg_step(inout logic [31:0] state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state;
	endfunction

	// OR of every image address, byte 0 adds nothing
	function automatic logic [ROM_ADDR_W-1:0] plain_mask(input int unsigned len);
		logic [ROM_ADDR_W-1:0] m;
		m = '0;
		for (int unsigned a = 1; a < len; a++)
			m = m | ROM_ADDR_W'(a);
		return m;
	endfunction

	// Same over the addresses behind the copier header
	function automatic logic [ROM_ADDR_W-1:0] header_strip_mask(input int unsigned len);
		logic [ROM_ADDR_W-1:0] m;
		m = '0;
		for (int unsigned a = cart_pkg::HEADER_BYTES; a < len; a++)
			m = m | ROM_ADDR_W'(a - cart_pkg::HEADER_BYTES);
		return m;
	endfunction

	// Four bytes per field, lower offset is the lower byte
	task automatic place_cheat_byte(inout cart_pkg::cheat_code_t rec, input int unsigned ofs,
			input logic [7:0] data);
		case (ofs / 4)
			0: rec.flags[(ofs % 4)*8 +: 8]   = data;
			1: rec.addr[(ofs % 4)*8 +: 8]    = data;
			2: rec.compare[(ofs % 4)*8 +: 8] = data;
			3: rec.replace[(ofs % 4)*8 +: 8] = data;
			default: ;
		endcase
	endtask

	// ====================
	// Compare tasks
	// ====================

	task automatic check_write(input cart_pkg::rom_write_t got, input cart_pkg::rom_write_t exp);
		if (got !== exp)
			fail_run($sformatf("ERR rom_write got addr %h data %h exp addr %h data %h",
				got.addr, got.data, exp.addr, exp.data));
	endtask

	task automatic check_cheat(input cart_pkg::cheat_code_t got, input cart_pkg::cheat_code_t exp);
		if (got !== exp)
			fail_run($sformatf("ERR cheat_code got %h exp %h", got, exp));
	endtask

	task automatic check_map(input logic [ROM_ADDR_W-1:0] got, input logic [ROM_ADDR_W-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR map_addr got %h exp %h", got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got %h exp %h", name, got, exp));
	endtask

`endif

/* tests/tb_cart_loader.sv */
// Cartridge loader testbench: clock, reset, loader and console stimulus, monitors, watchdog
module tb_cart_loader;

	localparam int ROM_ADDR_W = 22;
	localparam int NUM_CHEATS = 4;
	localparam int NUM_READS  = 64;

	logic                  clk_sys = 1'b0;
	logic                  reset;
	logic                  download;
	logic                  ioctl_valid;
	cart_pkg::ioctl_beat_t ioctl_beat;
	logic                  ioctl_ready;
	logic                  rom_valid;
	cart_pkg::rom_write_t  rom_write;
	logic                  rom_ready = 1'b0;   // Memory side back-pressure
	logic                  cheat_valid_out;
	cart_pkg::cheat_code_t cheat_code;
	logic                  rd_valid;
	logic [ROM_ADDR_W-1:0] rd_addr;
	logic                  map_valid;
	logic [ROM_ADDR_W-1:0] map_addr;
	logic                  game_gear;

	logic [31:0] stim_state  = 32'h397f;
	logic [31:0] ready_state = 32'h397f;
	int unsigned beat_total;
	int unsigned len_plain;
	int unsigned len_header;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "tb_cart_model.svh"

	cart_loader #(.ROM_ADDR_W(ROM_ADDR_W)) i_cart_loader (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.download        (download),
		.ioctl_valid     (ioctl_valid),
		.ioctl_beat      (ioctl_beat),
		.ioctl_ready     (ioctl_ready),
		.rom_valid       (rom_valid),
		.rom_write       (rom_write),
		.rom_ready       (rom_ready),
		.cheat_valid_out (cheat_valid_out),
		.cheat_code      (cheat_code),
		.rd_valid        (rd_valid),
		.rd_addr         (rd_addr),
		.map_valid       (map_valid),
		.map_addr        (map_addr),
		.game_gear       (game_gear)
	);

	always #50 clk_sys = ~clk_sys;

	function automatic int unsigned rand_below(input int unsigned n);
		return (lcg_step(stim_state) >> 8) % n;
	endfunction

	// Last address picked so bit 9 matches the header case
	function automatic int unsigned pick_length(input logic header);
		int unsigned last;
		if (header)
			last = (rand_below(2) == 0) ? 512 + rand_below(512) : 1536 + rand_below(463);
		else
			last = (rand_below(2) == 0) ? 299 + rand_below(213) : 1024 + rand_below(512);
		return last + 1;
	endfunction

	// ====================
	// Loader side
	// ====================

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send_beat(input logic [24:0] addr, input logic [7:0] data,
			input logic [7:0] index);
		logic accepted;
		ioctl_valid      = 1'b1;
		ioctl_beat.addr  = addr;
		ioctl_beat.data  = data;
		ioctl_beat.index = index;
		do begin
			#10;
			accepted = ioctl_ready;   // Settled until the rising edge
			@(negedge clk_sys);
		end while (!accepted);
		ioctl_valid = 1'b0;
	endtask

	task automatic load_image(input int unsigned len, input logic [7:0] index);
		cart_pkg::rom_write_t w;
		logic [7:0]           data;
		download = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (int unsigned a = 0; a < len; a++) begin
			data   = 8'(rand_below(256));
			w.addr = 24'(a);
			w.data = data;
			exp_writes.push_back(w);
			send_beat(25'(a), data, index);
		end
		while (exp_writes.size() != 0)
			@(negedge clk_sys);
		download = 1'b0;
		repeat (4) @(negedge clk_sys);   // End event and header latch
	endtask

	task automatic load_cheats(input int unsigned count);
		cart_pkg::cheat_code_t rec;
		logic [7:0]            bytes [16];
		download = 1'b1;
		repeat (2) @(negedge clk_sys);
		for (int unsigned r = 0; r < count; r++) begin
			rec = '0;
			for (int unsigned ofs = 0; ofs < 16; ofs++) begin
				bytes[ofs] = 8'(rand_below(256));
				place_cheat_byte(rec, ofs, bytes[ofs]);
			end
			exp_cheats.push_back(rec);
			for (int unsigned ofs = 0; ofs < 16; ofs++)
				send_beat(25'(r*16 + ofs), bytes[ofs], cart_pkg::CHEAT_INDEX);
		end
		while (exp_cheats.size() != 0)
			@(negedge clk_sys);
		download = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	// ====================
	// Console reads
	// ====================
	task automatic run_reads(input int unsigned count, input logic header,
			input logic [ROM_ADDR_W-1:0] mask);
		logic [ROM_ADDR_W-1:0] a;
		for (int unsigned i = 0; i < count; i++) begin
			a        = ROM_ADDR_W'(rand_below(32'd1 << ROM_ADDR_W));
			rd_valid = 1'b1;
			rd_addr  = a;
			if (header)
				exp_maps.push_back((a + ROM_ADDR_W'(cart_pkg::HEADER_BYTES)) & mask);
			else
				exp_maps.push_back(a & mask);
			@(negedge clk_sys);
		end
		rd_valid = 1'b0;
		while (exp_maps.size() != 0)
			@(negedge clk_sys);
	endtask

	// Memory ready about two cycles in three, outputs checked mid-cycle
	always @(negedge clk_sys) begin
		rom_ready = (((lcg_step(ready_state) >> 8) % 32'd3) != 32'd0);
		#10;
		if (rom_valid && rom_ready) begin
			if (exp_writes.size() == 0)
				fail_run($sformatf("Memory write to %h arrived with none expected", rom_write.addr));
			else
				check_write(rom_write, exp_writes.pop_front());
		end
		if (cheat_valid_out) begin
			if (exp_cheats.size() == 0)
				fail_run("A cheat record came out with none expected");
			else
				check_cheat(cheat_code, exp_cheats.pop_front());
		end
		if (map_valid) begin
			if (exp_maps.size() == 0)
				fail_run("A mapped read came out with none expected");
			else
				check_map(map_addr, exp_maps.pop_front());
		end
	end

	initial begin
		wait (beat_total != 0);
		repeat (beat_total * 20 + 1000) @(posedge clk_sys);
		fail_run("Timeout, the tests did not finish in the expected time");
	end

	// ====================
	// Test sequence
	// ====================
	initial begin
		reset       = 1'b1;
		download    = 1'b0;
		ioctl_valid = 1'b0;
		ioctl_beat  = '0;
		rd_valid    = 1'b0;
		rd_addr     = '0;

		len_plain  = pick_length(1'b0);
		len_header = pick_length(1'b1);
		beat_total = len_plain + len_header + NUM_CHEATS*16 + 2*NUM_READS;

		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		#10;
		check_flag("rom_valid", rom_valid, 1'b0);
		check_flag("cheat_valid_out", cheat_valid_out, 1'b0);
		check_flag("map_valid", map_valid, 1'b0);
		check_flag("game_gear", game_gear, 1'b0);
		@(negedge clk_sys);

		load_image(len_plain, 8'h22);      // Handheld index in the low bits
		check_flag("game_gear", game_gear, 1'b1);
		run_reads(NUM_READS, 1'b0, plain_mask(len_plain));

		load_cheats(NUM_CHEATS);

		load_image(len_header, 8'h01);
		check_flag("game_gear", game_gear, 1'b0);
		run_reads(NUM_READS, 1'b1, header_strip_mask(len_header));

		repeat (4) @(negedge clk_sys);   // Room for any stray output
		$display(">>> PASS");
		$finish;
	end

endmodule

/* hw/cart_loader.sv */
// Cartridge loading top: load decoder, ROM writer, cheat assembler and ROM address mapper
module cart_loader #(
	parameter int ROM_ADDR_W = 22
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  download,
	input  logic                  ioctl_valid,
	input  cart_pkg::ioctl_beat_t ioctl_beat,
	output logic                  ioctl_ready,
	output logic                  rom_valid,
	output cart_pkg::rom_write_t  rom_write,
	input  logic                  rom_ready,
	output logic                  cheat_valid_out,
	output cart_pkg::cheat_code_t cheat_code,
	input  logic                  rd_valid,
	input  logic [ROM_ADDR_W-1:0] rd_addr,
	output logic                  map_valid,
	output logic [ROM_ADDR_W-1:0] map_addr,
	output logic                  game_gear
);

	logic                  cart_valid;
	logic                  cheat_valid;
	logic                  cart_ready;
	cart_pkg::cart_beat_t  beat;         // Shared by cart and cheat paths
	cart_pkg::load_event_t load_event;

	// ====================
	// Stages
	// ====================
	load_decoder i_load_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download    (download),
		.ioctl_valid (ioctl_valid),
		.ioctl_beat  (ioctl_beat),
		.ioctl_ready (ioctl_ready),
		.cart_valid  (cart_valid),
		.cheat_valid (cheat_valid),
		.beat        (beat),
		.cart_ready  (cart_ready),
		.load_event  (load_event),
		.game_gear   (game_gear)
	);

	rom_writer #(.ROM_ADDR_W(ROM_ADDR_W)) i_rom_writer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_event (load_event),
		.cart_valid (cart_valid),
		.beat       (beat),
		.cart_ready (cart_ready),
		.rom_valid  (rom_valid),
		.rom_write  (rom_write),
		.rom_ready  (rom_ready)
	);

	cheat_assembler i_cheat_assembler (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cheat_valid     (cheat_valid),
		.beat            (beat),
		.cheat_valid_out (cheat_valid_out),
		.cheat_code      (cheat_code)
	);

	// Watches the same cart handshake as the writer
	rom_map #(.ROM_ADDR_W(ROM_ADDR_W)) i_rom_map (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_event (load_event),
		.cart_valid (cart_valid),
		.cart_ready (cart_ready),
		.beat       (beat),
		.rd_valid   (rd_valid),
		.rd_addr    (rd_addr),
		.map_valid  (map_valid),
		.map_addr   (map_addr)
	);

endmodule

/* hw/rom_map.sv */
// Image size masks, copier header detection and console ROM read address mapping
module rom_map #(
	parameter int ROM_ADDR_W = 22
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::load_event_t load_event,
	input  logic                  cart_valid,
	input  logic                  cart_ready,
	input  cart_pkg::cart_beat_t  beat,
	input  logic                  rd_valid,
	input  logic [ROM_ADDR_W-1:0] rd_addr,
	output logic                  map_valid,
	output logic [ROM_ADDR_W-1:0] map_addr
);

	localparam logic [ROM_ADDR_W-1:0] HDR = ROM_ADDR_W'(cart_pkg::HEADER_BYTES);

	logic [ROM_ADDR_W-1:0] cart_mask;     // OR of all image addresses
	logic [ROM_ADDR_W-1:0] header_mask;   // Same, header stripped
	logic [ROM_ADDR_W-1:0] addr_lo;
	logic                  xfer;
	logic                  last_a9;
	logic                  has_header;

	assign xfer    = cart_valid && cart_ready;
	assign addr_lo = beat.addr[ROM_ADDR_W-1:0];

	// ====================
	// Mask learning
	// ====================
	always_ff @(posedge clk_sys) begin
		if (xfer) begin
			if (beat.first)
				cart_mask <= '0;
			else
				cart_mask <= cart_mask | addr_lo;

			// Values below the header wrap, cleared once byte 512 arrives
			if (beat.addr == cart_pkg::IOCTL_ADDR_W'(cart_pkg::HEADER_BYTES))
				header_mask <= '0;
			else
				header_mask <= header_mask | (addr_lo - HDR);

			last_a9 <= beat.addr[9];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			has_header <= 1'b0;
		else if (load_event == cart_pkg::EV_END)
			has_header <= last_a9;   // Odd 512 block left over means a header
	end

	// ====================
	// Read mapping
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset)
			map_valid <= 1'b0;
		else
			map_valid <= rd_valid;

		if (rd_valid) begin
			if (has_header)
				map_addr <= (rd_addr + HDR) & header_mask;
			else
				map_addr <= rd_addr & cart_mask;
		end
	end

endmodule

/* hw/cheat_assembler.sv */
// Cheat record builder from 16 loader bytes with one-cycle record pulse
module cheat_assembler (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cheat_valid,
	input  cart_pkg::cart_beat_t  beat,
	output logic                  cheat_valid_out,
	output cart_pkg::cheat_code_t cheat_code
);

	cart_pkg::cheat_code_t work;      // Record under construction
	logic                  last_seen;
	logic [1:0]            sel;       // Byte within the field

	assign sel = beat.addr[1:0];

	// ====================
	// Byte placement
	// ====================
	always_ff @(posedge clk_sys) begin
		if (cheat_valid) begin
			case (beat.addr[3:2])
				2'd0: work.flags[sel*8 +: 8]   <= beat.data;
				2'd1: work.addr[sel*8 +: 8]    <= beat.data;
				2'd2: work.compare[sel*8 +: 8] <= beat.data;
				2'd3: work.replace[sel*8 +: 8] <= beat.data;
				default: ;
			endcase
		end

		if (last_seen)
			cheat_code <= work;   // Copy of the finished record
	end

	// ====================
	// Record pulse
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_seen       <= 1'b0;
			cheat_valid_out <= 1'b0;
		end else begin
			last_seen       <= cheat_valid && (beat.addr[3:0] == 4'hf);
			cheat_valid_out <= last_seen;
		end
	end

endmodule

/* hw/rom_writer.sv */
// Sequential ROM write generator with held valid/ready output register and address counter
module rom_writer #(
	parameter int ROM_ADDR_W = 22
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cart_pkg::load_event_t load_event,
	input  logic                  cart_valid,
	input  cart_pkg::cart_beat_t  beat,
	output logic                  cart_ready,
	output logic                  rom_valid,
	output cart_pkg::rom_write_t  rom_write,
	input  logic                  rom_ready
);

	logic [ROM_ADDR_W-1:0] wr_addr;       // Writes completed in this load
	logic [ROM_ADDR_W-1:0] cnt_next;
	logic                  done;
	logic                  take;

	assign done       = rom_valid && rom_ready;
	assign cart_ready = !rom_valid || rom_ready;   // Free now or freed this edge
	assign take       = cart_valid && cart_ready;

	// Counter after this edge, restarts with each load
	always_comb begin
		if (load_event == cart_pkg::EV_START)
			cnt_next = '0;
		else
			cnt_next = wr_addr + ROM_ADDR_W'(done);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_addr   <= '0;
			rom_valid <= 1'b0;
		end else begin
			wr_addr <= cnt_next;
			if (take)
				rom_valid <= 1'b1;
			else if (done)
				rom_valid <= 1'b0;
		end

		// Held until the memory takes it
		if (take) begin
			rom_write.addr <= 24'(cnt_next);
			rom_write.data <= beat.data;
		end
	end

endmodule

/* hw/load_decoder.sv */
// Loader skid register, cart/cheat classification, handheld flag, download start/end events
module load_decoder (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 download,
	input  logic                 ioctl_valid,
	input  cart_pkg::ioctl_beat_t ioctl_beat,
	output logic                 ioctl_ready,
	output logic                 cart_valid,
	output logic                 cheat_valid,
	output cart_pkg::cart_beat_t beat,
	input  logic                 cart_ready,
	output cart_pkg::load_event_t load_event,
	output logic                 game_gear
);

	logic                 full;
	cart_pkg::beat_kind_t kind;
	logic                 taken;
	logic                 accept;
	logic                 download_d;
	logic                 end_pending;
	logic                 cart_held;

	// Cheat beats never wait
	assign taken       = (kind == cart_pkg::BEAT_CHEAT) || cart_ready;
	assign ioctl_ready = !full || taken;
	assign accept      = ioctl_valid && ioctl_ready;

	assign cart_valid  = full && (kind == cart_pkg::BEAT_CART);
	assign cheat_valid = full && (kind == cart_pkg::BEAT_CHEAT);
	assign cart_held   = cart_valid;

	// ====================
	// Beat register
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			full      <= 1'b0;
			game_gear <= 1'b0;
		end else if (accept) begin
			full <= 1'b1;
			if (ioctl_beat.index != cart_pkg::CHEAT_INDEX)
				game_gear <= (ioctl_beat.index[4:0] == cart_pkg::GG_INDEX);
		end else if (full && taken) begin
			full <= 1'b0;
		end

		if (accept) begin
			beat.addr  <= ioctl_beat.addr;
			beat.data  <= ioctl_beat.data;
			beat.first <= (ioctl_beat.addr == '0);
			kind       <= (ioctl_beat.index == cart_pkg::CHEAT_INDEX) ?
				cart_pkg::BEAT_CHEAT : cart_pkg::BEAT_CART;
		end
	end

	// ====================
	// Download edges
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_d  <= 1'b0;
			end_pending <= 1'b0;
			load_event  <= cart_pkg::EV_NONE;
		end else begin
			download_d <= download;
			load_event <= cart_pkg::EV_NONE;
			if (download && !download_d) begin
				load_event  <= cart_pkg::EV_START;
				end_pending <= 1'b0;
			end else if ((end_pending || (!download && download_d)) && !cart_held) begin
				load_event  <= cart_pkg::EV_END;   // Only once the last cart byte has left
				end_pending <= 1'b0;
			end else if (!download && download_d) begin
				end_pending <= 1'b1;
			end
		end
	end

endmodule

/* hw/cart_pkg.sv */
// Loader widths, cheat and handheld index codes, event enums, beat/write/cheat structs
package cart_pkg;

	// ====================
	// Constants
	// ====================

	localparam int IOCTL_ADDR_W = 25;        // Byte address of the host loader

	localparam logic [7:0] CHEAT_INDEX = 8'hff;   // Index of a cheat code file
	localparam logic [4:0] GG_INDEX    = 5'd2;    // Low index bits of a handheld cart

	localparam int unsigned HEADER_BYTES = 512;   // Copier header in front of some images

	// ====================
	// Enums
	// ====================

	typedef enum logic {
		BEAT_CART,
		BEAT_CHEAT
	} beat_kind_t;

	// One-cycle download markers
	typedef enum logic [1:0] {
		EV_NONE,
		EV_START,
		EV_END
	} load_event_t;

	// ====================
	// Structs
	// ====================

	typedef struct packed {
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [7:0]              data;
		logic [7:0]              index;
	} ioctl_beat_t;

	typedef struct packed {
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [7:0]              data;
		logic                    first;     // Byte 0 of an image
	} cart_beat_t;

	typedef struct packed {
		logic [23:0] addr;
		logic [7:0]  data;
	} rom_write_t;

	// Flags on top, replace value at the bottom
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage
